// File: files.f
src/bmc_pkg.sv
src/bus_decode.sv
src/sys_config_regs.sv
src/irq_controller.sv
src/bus_execute.sv
src/bus_response.sv
src/bmc_top.sv
tests/bmc_assert.sv
tests/bmc_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bmc_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/bmc_tb.sv
`timescale 1ns/1ps

module bmc_tb;
  import bmc_pkg::*;

  localparam logic [15:0] EXP_BOARD_ID = 16'h0a5c;
  localparam logic [15:0] EXP_REVISION = 16'h0307;
  localparam int N_ID    = 2;
  localparam int N_RW    = 32;
  localparam int N_RO    = 4;
  localparam int N_UNMAP = 16;
  localparam int N_IRQ   = 13; // One mask write, then three commands per round
  localparam int N_MIXED = 200;
  localparam int TOTAL_CMDS     = N_ID + N_RW + N_RO + N_UNMAP + N_IRQ + N_MIXED;
  localparam int TIMEOUT_CYCLES = TOTAL_CMDS * 20 + 200;

  logic        gclk40 = 1'b0;
  logic        hard_reset;
  logic        cmd_valid_i;
  logic        cmd_ready_o;
  bus_cmd_t    cmd_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i = 1'b1;
  bus_rsp_t    rsp_o;
  logic [3:0]  irq_src_i;
  logic        irq_o;
  logic [7:0]  sys_config_o;

  logic [31:0] stim_state = 32'h8d8a;
  logic [31:0] bp_state   = 32'h8d8a;
  logic        bp_en      = 1'b0;
  bus_rsp_t    exp_q[$];
  int          err_cnt       = 0;
  int          check_cnt     = 0;
  int          mon_err_cnt   = 0;
  int          mon_check_cnt = 0;
  int          cmd_cnt       = 0;

  // Reference state of the register slaves
  logic [7:0]  model_config  = 8'h00;
  logic [15:0] model_scratch = 16'h0000;
  logic [3:0]  model_status  = 4'h0;
  logic [3:0]  model_mask    = 4'h0;

  bmc_top #(
    .BOARD_ID        (16'h0a5c),
    .REV_MAJOR       (8'd3),
    .REV_MINOR       (8'd7),
    .NUM_IRQ_SOURCES (4)
  ) dut (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_i        (cmd_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_o        (rsp_o),
    .irq_src_i    (irq_src_i),
    .irq_o        (irq_o),
    .sys_config_o (sys_config_o)
  );

  bind bus_response bmc_assert bmc_assert_inst (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_i       (rsp_o)
  );

  always #50 gclk40 = ~gclk40;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] rand_word();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  function automatic int total_errors();
    return err_cnt + mon_err_cnt;
  endfunction

  // Moves a random address out of both slave windows
  function automatic logic [15:0] unmapped_addr(input logic [15:0] a);
    if (a <= 16'h0003 || a == 16'h0100 || a == 16'h0101) begin
      return a | 16'h0200;
    end
    return a;
  endfunction

  // Expected response of one command, updating the register model as the DUT would
  function automatic bus_rsp_t model_access(input logic we, input logic [15:0] addr,
                                            input logic [15:0] wdata);
    bus_rsp_t rsp;
    rsp = '0;
    if (addr <= 16'h0003) begin
      if (we && addr[1] == 1'b0) begin // Board id and revision cannot be written
        rsp.err                = 1'b1;
        rsp.word.fault.cause   = FAULT_RO_WRITE;
        rsp.word.fault.addr_lo = addr[11:0];
      end else if (we && addr[0] == 1'b0) begin
        model_config = wdata[7:0];
      end else if (we) begin
        model_scratch = wdata;
      end else begin
        case (addr[1:0])
          2'd0:    rsp.word.read_data = EXP_BOARD_ID;
          2'd1:    rsp.word.read_data = EXP_REVISION;
          2'd2:    rsp.word.read_data = {8'h00, model_config};
          default: rsp.word.read_data = model_scratch;
        endcase
      end
    end else if (addr == 16'h0100 || addr == 16'h0101) begin
      if (we && addr[0] == 1'b0) begin
        model_status = model_status & ~wdata[3:0];
      end else if (we) begin
        model_mask = wdata[3:0];
      end else if (addr[0]) begin
        rsp.word.read_data = {12'h000, model_mask};
      end else begin
        rsp.word.read_data = {12'h000, model_status};
      end
    end else begin
      rsp.err                = 1'b1;
      rsp.word.fault.cause   = FAULT_UNMAPPED;
      rsp.word.fault.addr_lo = addr[11:0];
    end
    return rsp;
  endfunction

  // Holds the command until the decode stage takes it, then queues its expected response
  task automatic issue_cmd(input logic we, input logic [15:0] addr, input logic [15:0] wdata);
    cmd_valid_i = 1'b1;
    cmd_i.we    = we;
    cmd_i.addr  = addr;
    cmd_i.wdata = wdata;
    @(posedge gclk40);
    while (!cmd_ready_o) @(posedge gclk40);
    exp_q.push_back(model_access(we, addr, wdata));
    cmd_cnt++;
    @(negedge gclk40);
    cmd_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) @(negedge gclk40);
    @(negedge gclk40);
  endtask

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int start_errs);
    $display("Test %-20s done with %0d errors", name, total_errors() - start_errs);
  endtask

  task automatic compare_response();
    bus_rsp_t exp;
    if (exp_q.size() == 0) begin
      $display("Response %h arrived at %0t with no command outstanding", rsp_o, $time);
      mon_err_cnt++;
    end else begin
      exp = exp_q.pop_front();
      mon_check_cnt++;
      if (rsp_o !== exp) begin
        $display("Fail at %0t: response err=%b word=%h, expected err=%b word=%h",
                 $time, rsp_o.err, rsp_o.word.read_data, exp.err, exp.word.read_data);
        mon_err_cnt++;
      end
    end
  endtask

  always @(posedge gclk40) begin
    if (hard_reset && rsp_valid_o && rsp_ready_i) begin
      compare_response();
    end
  end

  // Master stalls about half of the cycles when back-pressure is on
  always @(negedge gclk40) begin
    if (bp_en) begin
      bp_state    = lcg_step(bp_state);
      rsp_ready_i = bp_state[24];
    end else begin
      rsp_ready_i = 1'b1;
    end
  end

  initial begin
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge gclk40);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [15:0] addr;
    logic [3:0]  src;
    int          t0;
    int          total;
    hard_reset  = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    irq_src_i   = '0;
    repeat (10) @(negedge gclk40);
    hard_reset = 1'b1;
    @(negedge gclk40);

    t0 = total_errors();
    check_value("cmd_ready_o after reset", {15'h0000, cmd_ready_o}, 16'h0001);
    check_value("rsp_valid_o after reset", {15'h0000, rsp_valid_o}, 16'h0000);
    check_value("irq_o after reset", {15'h0000, irq_o}, 16'h0000);
    check_value("sys_config_o after reset", {8'h00, sys_config_o}, 16'h0000);
    issue_cmd(1'b0, 16'h0000, 16'h0000);
    issue_cmd(1'b0, 16'h0001, 16'h0000);
    wait_idle();
    report_test("identity reads", t0);

    t0 = total_errors();
    for (int i = 0; i < N_RW / 2; i++) begin
      r    = rand_word();
      addr = r[0] ? 16'h0003 : 16'h0002;
      issue_cmd(1'b1, addr, r[31:16]);
      issue_cmd(1'b0, addr, 16'h0000);
    end
    wait_idle();
    check_value("sys_config_o", {8'h00, sys_config_o}, {8'h00, model_config});
    report_test("config and scratch", t0);

    t0 = total_errors();
    r  = rand_word();
    issue_cmd(1'b1, 16'h0000, r[15:0]);
    issue_cmd(1'b1, 16'h0001, r[31:16]);
    issue_cmd(1'b0, 16'h0000, 16'h0000);
    issue_cmd(1'b0, 16'h0001, 16'h0000);
    wait_idle();
    report_test("read-only writes", t0);

    t0 = total_errors();
    for (int i = 0; i < N_UNMAP; i++) begin
      r = rand_word();
      issue_cmd(r[20], unmapped_addr(r[15:0]), r[31:16]);
    end
    wait_idle();
    report_test("unmapped addresses", t0);

    t0 = total_errors();
    r  = rand_word();
    issue_cmd(1'b1, 16'h0101, r[31:16]);
    wait_idle();
    for (int rnd = 0; rnd < 4; rnd++) begin
      r         = rand_word();
      src       = r[19:16] | (4'b0001 << rnd);
      irq_src_i = src;
      repeat (2) @(negedge gclk40);
      model_status = model_status | src; // Sticky bits follow the sources
      issue_cmd(1'b0, 16'h0100, 16'h0000);
      wait_idle();
      check_value("irq_o", {15'h0000, irq_o}, {15'h0000, |(model_status & model_mask)});
      irq_src_i = 4'h0;
      repeat (2) @(negedge gclk40);
      // Bit rnd is written as zero, so it must survive the clear
      issue_cmd(1'b1, 16'h0100, {r[15:4], src & ~(4'b0001 << rnd)});
      issue_cmd(1'b0, 16'h0100, 16'h0000);
      wait_idle();
      check_value("irq_o", {15'h0000, irq_o}, {15'h0000, |(model_status & model_mask)});
    end
    report_test("interrupts", t0);

    t0    = total_errors();
    bp_en = 1'b1;
    for (int i = 0; i < N_MIXED; i++) begin
      r = rand_word();
      case (r[2:0])
        3'd4, 3'd5: addr = {15'h0080, r[3]};
        3'd6, 3'd7: addr = unmapped_addr(r[31:16]);
        default:    addr = {14'h0000, r[4:3]};
      endcase
      issue_cmd(r[5], addr, r[31:16]);
    end
    wait_idle();
    bp_en = 1'b0;
    check_value("sys_config_o", {8'h00, sys_config_o}, {8'h00, model_config});
    report_test("mixed back-pressure", t0);

    total = total_errors() + dut.bus_response_inst.bmc_assert_inst.fail_cnt;
    $display("Summary: %0d commands, %0d checks, %0d errors",
             cmd_cnt, check_cnt + mon_check_cnt, total);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: tests/bmc_assert.sv
`timescale 1ns/1ps

module bmc_assert (
  input logic              gclk40,
  input logic              hard_reset,
  input logic              rsp_valid_i,
  input logic              rsp_ready_i,
  input bmc_pkg::bus_rsp_t rsp_i
);

  int fail_cnt = 0; // Read by the testbench at the end of the run

  // The result stage must come out of reset empty
  reset_empties_stage: assert property (@(posedge gclk40) !hard_reset |=> !rsp_valid_i)
    else begin
      fail_cnt++;
      $error("rsp_valid_o is high in the cycle after reset");
    end

  held_rsp_stable: assert property (@(posedge gclk40) disable iff (!hard_reset)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
      fail_cnt++;
      $error("Stalled response changed or was dropped before it was taken");
    end

  valid_rsp_known: assert property (@(posedge gclk40) disable iff (!hard_reset)
    rsp_valid_i |-> !$isunknown(rsp_i))
    else begin
      fail_cnt++;
      $error("Response word has unknown bits while valid");
    end

endmodule

// File: src/bmc_top.sv
`timescale 1ns/1ps

module bmc_top #(
  parameter logic [15:0] BOARD_ID        = 16'h0000,
  parameter logic [7:0]  REV_MAJOR       = 8'd0,
  parameter logic [7:0]  REV_MINOR       = 8'd0,
  parameter int          NUM_IRQ_SOURCES = 4
) (
  input  logic                       gclk40,
  input  logic                       hard_reset,
  input  logic                       cmd_valid_i,
  output logic                       cmd_ready_o,
  input  bmc_pkg::bus_cmd_t          cmd_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output bmc_pkg::bus_rsp_t          rsp_o,
  input  logic [NUM_IRQ_SOURCES-1:0] irq_src_i,
  output logic                       irq_o,
  output logic [7:0]                 sys_config_o
);
  import bmc_pkg::*;

  logic       dec_valid;
  logic       dec_ready;
  dec_cmd_t   dec_cmd;
  logic       exe_valid;
  logic       exe_ready;
  slave_rsp_t exe_rsp;

  bus_decode bus_decode_inst (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .dec_valid_o (dec_valid),
    .dec_ready_i (dec_ready),
    .dec_cmd_o   (dec_cmd)
  );

  bus_execute #(
    .BOARD_ID        (BOARD_ID),
    .REV_MAJOR       (REV_MAJOR),
    .REV_MINOR       (REV_MINOR),
    .NUM_IRQ_SOURCES (NUM_IRQ_SOURCES)
  ) bus_execute_inst (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .dec_valid_i  (dec_valid),
    .dec_ready_o  (dec_ready),
    .dec_cmd_i    (dec_cmd),
    .exe_valid_o  (exe_valid),
    .exe_ready_i  (exe_ready),
    .exe_rsp_o    (exe_rsp),
    .irq_src_i    (irq_src_i),
    .irq_o        (irq_o),
    .sys_config_o (sys_config_o)
  );

  bus_response bus_response_inst (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .exe_valid_i (exe_valid),
    .exe_ready_o (exe_ready),
    .exe_rsp_i   (exe_rsp),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

endmodule

// File: src/bus_response.sv
`timescale 1ns/1ps

module bus_response (
  input  logic                gclk40,
  input  logic                hard_reset,
  input  logic                exe_valid_i,
  output logic                exe_ready_o,
  input  bmc_pkg::slave_rsp_t exe_rsp_i,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output bmc_pkg::bus_rsp_t   rsp_o
);
  import bmc_pkg::*;

  logic     rsp_valid_q;
  bus_rsp_t rsp_q;

  // Holds the current word while the master stalls
  assign exe_ready_o = !rsp_valid_q || rsp_ready_i;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      rsp_valid_q <= 1'b0;
    end else if (exe_ready_o) begin
      rsp_valid_q <= exe_valid_i;
    end
  end

  always_ff @(posedge gclk40) begin
    if (exe_valid_i && exe_ready_o) begin
      rsp_q.err  <= exe_rsp_i.err;
      rsp_q.word <= exe_rsp_i.word; // Union passes through unchanged
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// File: src/bus_execute.sv
`timescale 1ns/1ps

module bus_execute #(
  parameter logic [15:0] BOARD_ID        = 16'h0000,
  parameter logic [7:0]  REV_MAJOR       = 8'd0,
  parameter logic [7:0]  REV_MINOR       = 8'd0,
  parameter int          NUM_IRQ_SOURCES = 4
) (
  input  logic                       gclk40,
  input  logic                       hard_reset,
  input  logic                       dec_valid_i,
  output logic                       dec_ready_o,
  input  bmc_pkg::dec_cmd_t          dec_cmd_i,
  output logic                       exe_valid_o,
  input  logic                       exe_ready_i,
  output bmc_pkg::slave_rsp_t        exe_rsp_o,
  input  logic [NUM_IRQ_SOURCES-1:0] irq_src_i,
  output logic                       irq_o,
  output logic [7:0]                 sys_config_o
);
  import bmc_pkg::*;

  logic       exe_valid_q;
  slave_rsp_t exe_rsp_q;
  slave_rsp_t exe_nxt;
  slave_rsp_t sc_rsp;
  slave_rsp_t irq_rsp;
  logic       accept;

  assign dec_ready_o = !exe_valid_q || exe_ready_i;
  assign accept      = dec_valid_i && dec_ready_o;

  sys_config_regs #(
    .BOARD_ID  (BOARD_ID),
    .REV_MAJOR (REV_MAJOR),
    .REV_MINOR (REV_MINOR)
  ) sys_config_regs_inst (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .access_i     (accept && dec_cmd_i.target == TGT_SYSCONF),
    .cmd_i        (dec_cmd_i),
    .rsp_o        (sc_rsp),
    .sys_config_o (sys_config_o)
  );

  irq_controller #(
    .NUM_IRQ_SOURCES (NUM_IRQ_SOURCES)
  ) irq_controller_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .access_i   (accept && dec_cmd_i.target == TGT_IRQ),
    .cmd_i      (dec_cmd_i),
    .rsp_o      (irq_rsp),
    .irq_src_i  (irq_src_i),
    .irq_o      (irq_o)
  );

  always_comb begin
    exe_nxt = '0;
    case (dec_cmd_i.target)
      TGT_SYSCONF: exe_nxt = sc_rsp;
      TGT_IRQ:     exe_nxt = irq_rsp;
      default: begin // No slave claimed the address
        exe_nxt.err                = 1'b1;
        exe_nxt.word.fault.cause   = FAULT_UNMAPPED;
        exe_nxt.word.fault.addr_lo = dec_cmd_i.cmd.addr[11:0];
      end
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      exe_valid_q <= 1'b0;
    end else if (dec_ready_o) begin
      exe_valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge gclk40) begin
    if (accept) begin
      exe_rsp_q <= exe_nxt;
    end
  end

  assign exe_valid_o = exe_valid_q;
  assign exe_rsp_o   = exe_rsp_q;

endmodule

// File: src/irq_controller.sv
`timescale 1ns/1ps

module irq_controller #(
  parameter int NUM_IRQ_SOURCES = 4
) (
  input  logic                       gclk40,
  input  logic                       hard_reset,
  input  logic                       access_i,
  input  bmc_pkg::dec_cmd_t          cmd_i,
  output bmc_pkg::slave_rsp_t        rsp_o,
  input  logic [NUM_IRQ_SOURCES-1:0] irq_src_i,
  output logic                       irq_o
);
  import bmc_pkg::*;

  logic [NUM_IRQ_SOURCES-1:0] status_q;
  logic [NUM_IRQ_SOURCES-1:0] mask_q;
  logic [NUM_IRQ_SOURCES-1:0] status_nxt;
  logic [NUM_IRQ_SOURCES-1:0] mask_nxt;
  logic                       irq_q;
  logic                       wr_en;

  assign wr_en = access_i && cmd_i.cmd.we;

  always_comb begin
    status_nxt = status_q;
    mask_nxt   = mask_q;
    if (wr_en && cmd_i.reg_idx == IRQ_STATUS) begin
      status_nxt = status_q & ~cmd_i.cmd.wdata[NUM_IRQ_SOURCES-1:0]; // Write one to clear
    end
    if (wr_en && cmd_i.reg_idx == IRQ_MASK) begin
      mask_nxt = cmd_i.cmd.wdata[NUM_IRQ_SOURCES-1:0];
    end
    // A source that is still high wins over a clear in the same cycle
    status_nxt = status_nxt | irq_src_i;
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      status_q <= '0;
      mask_q   <= '0;
      irq_q    <= 1'b0;
    end else begin
      status_q <= status_nxt;
      mask_q   <= mask_nxt;
      irq_q    <= |(status_nxt & mask_nxt);
    end
  end

  always_comb begin
    rsp_o = '0;
    if (!cmd_i.cmd.we) begin
      if (cmd_i.reg_idx == IRQ_MASK) begin
        rsp_o.word.read_data = DATA_W'(mask_q);
      end else begin
        rsp_o.word.read_data = DATA_W'(status_q);
      end
    end
  end

  assign irq_o = irq_q;

endmodule

// File: src/sys_config_regs.sv
`timescale 1ns/1ps

module sys_config_regs #(
  parameter logic [15:0] BOARD_ID  = 16'h0000,
  parameter logic [7:0]  REV_MAJOR = 8'd0,
  parameter logic [7:0]  REV_MINOR = 8'd0
) (
  input  logic                gclk40,
  input  logic                hard_reset,
  input  logic                access_i,
  input  bmc_pkg::dec_cmd_t   cmd_i,
  output bmc_pkg::slave_rsp_t rsp_o,
  output logic [7:0]          sys_config_o
);
  import bmc_pkg::*;

  logic [7:0]        config_q;
  logic [DATA_W-1:0] scratch_q;
  logic              ro_reg;
  logic              wr_en;

  // Identity and revision are fixed at build time
  assign ro_reg = cmd_i.reg_idx == SC_BOARD_ID || cmd_i.reg_idx == SC_REVISION;
  assign wr_en  = access_i && cmd_i.cmd.we && !ro_reg;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      config_q  <= '0;
      scratch_q <= '0;
    end else if (wr_en) begin
      if (cmd_i.reg_idx == SC_CONFIG) begin
        config_q <= cmd_i.cmd.wdata[7:0];
      end
      if (cmd_i.reg_idx == SC_SCRATCH) begin
        scratch_q <= cmd_i.cmd.wdata;
      end
    end
  end

  always_comb begin
    rsp_o = '0;
    if (cmd_i.cmd.we) begin
      if (ro_reg) begin
        rsp_o.err                = 1'b1;
        rsp_o.word.fault.cause   = FAULT_RO_WRITE;
        rsp_o.word.fault.addr_lo = cmd_i.cmd.addr[11:0];
      end
    end else begin
      case (cmd_i.reg_idx)
        SC_BOARD_ID: rsp_o.word.read_data = BOARD_ID;
        SC_REVISION: rsp_o.word.read_data = {REV_MAJOR, REV_MINOR};
        SC_CONFIG:   rsp_o.word.read_data = {8'h00, config_q};
        default:     rsp_o.word.read_data = scratch_q;
      endcase
    end
  end

  assign sys_config_o = config_q; // Drives board pins

endmodule

// File: src/bus_decode.sv
`timescale 1ns/1ps

module bus_decode (
  input  logic              gclk40,
  input  logic              hard_reset,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,
  input  bmc_pkg::bus_cmd_t cmd_i,
  output logic              dec_valid_o,
  input  logic              dec_ready_i,
  output bmc_pkg::dec_cmd_t dec_cmd_o
);
  import bmc_pkg::*;

  localparam logic [ADDR_W-1:0] SYSCONF_HIGH = SYSCONF_BASE + ADDR_W'(SYSCONF_REGS - 1);
  localparam logic [ADDR_W-1:0] IRQ_HIGH     = IRQ_BASE + ADDR_W'(IRQ_REGS - 1);

  logic              dec_valid_q;
  dec_cmd_t          dec_cmd_q;
  target_e           target;
  logic [ADDR_W-1:0] offset;

  // Base and high limit compare per slave
  always_comb begin
    target = TGT_NONE;
    offset = '0;
    if (cmd_i.addr >= SYSCONF_BASE && cmd_i.addr <= SYSCONF_HIGH) begin
      target = TGT_SYSCONF;
      offset = cmd_i.addr - SYSCONF_BASE;
    end else if (cmd_i.addr >= IRQ_BASE && cmd_i.addr <= IRQ_HIGH) begin
      target = TGT_IRQ;
      offset = cmd_i.addr - IRQ_BASE;
    end
  end

  // Stage refills in the same cycle it is emptied
  assign cmd_ready_o = !dec_valid_q || dec_ready_i;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      dec_valid_q <= 1'b0;
    end else if (cmd_ready_o) begin
      dec_valid_q <= cmd_valid_i;
    end
  end

  always_ff @(posedge gclk40) begin
    if (cmd_valid_i && cmd_ready_o) begin
      dec_cmd_q.cmd     <= cmd_i;
      dec_cmd_q.target  <= target;
      dec_cmd_q.reg_idx <= offset[1:0]; // Both slaves fit in four registers
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_cmd_o   = dec_cmd_q;

endmodule

// File: src/bmc_pkg.sv
package bmc_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 16;

  // Address map, each slave occupies BASE up to BASE + REGS - 1
  localparam logic [ADDR_W-1:0] SYSCONF_BASE = 16'h0000;
  localparam int                SYSCONF_REGS = 4;
  localparam logic [ADDR_W-1:0] IRQ_BASE     = 16'h0100;
  localparam int                IRQ_REGS     = 2;

  localparam logic [1:0] SC_BOARD_ID = 2'd0;
  localparam logic [1:0] SC_REVISION = 2'd1;
  localparam logic [1:0] SC_CONFIG   = 2'd2;
  localparam logic [1:0] SC_SCRATCH  = 2'd3;
  localparam logic [1:0] IRQ_STATUS  = 2'd0;
  localparam logic [1:0] IRQ_MASK    = 2'd1;

  typedef enum logic [1:0] {TGT_SYSCONF, TGT_IRQ, TGT_NONE} target_e;

  typedef enum logic [3:0] {FAULT_NONE, FAULT_UNMAPPED, FAULT_RO_WRITE} fault_cause_e;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_cmd_t;

  typedef struct packed {
    bus_cmd_t   cmd;
    target_e    target;
    logic [1:0] reg_idx;
  } dec_cmd_t;

  typedef struct packed {
    fault_cause_e cause;
    logic [11:0]  addr_lo; // Low address bits of the failing access
  } fault_rec_t;

  // Read data on success, fault record when the error flag is set
  typedef union packed {
    logic [DATA_W-1:0] read_data;
    fault_rec_t        fault;
  } rsp_word_u;

  typedef struct packed {
    logic      err;
    rsp_word_u word;
  } slave_rsp_t;

  typedef struct packed {
    logic      err;
    rsp_word_u word;
  } bus_rsp_t;

endpackage
